//--- fir.f
+incdir+hw
+incdir+verif
hw/fir_pkg.sv
hw/sync_ram.sv
hw/axil_regs.sv
hw/fir_engine.sv
hw/fir_mac.sv
hw/fir_top.sv
verif/tb_fir.sv

//--- hw/axil_regs.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module axil_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               awvalid,
    output logic               awready,
    input  fir_pkg::fir_addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  fir_pkg::fir_data_t wdata,
    input  logic               arvalid,
    output logic               arready,
    input  fir_pkg::fir_addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output fir_pkg::fir_data_t rdata,
    input  logic               run_end,
    input  logic               ss_ready,
    input  logic               out_valid,
    input  fir_pkg::fir_data_t tap_rdata,
    output logic               start,
    output logic               cfg_tap_we,
    output fir_pkg::tap_idx_t  cfg_tap_idx,
    output fir_pkg::fir_data_t cfg_tap_wdata
);

    localparam fir_pkg::fir_addr_t TAP_SPAN = 4 * `FIR_NUM_TAPS;

    fir_pkg::wr_state_t wr_state, wr_state_nx;
    fir_pkg::fir_addr_t aw_q, ar_q, wr_off, rd_off;
    fir_pkg::fir_data_t w_q, data_length, status;
    logic wr_live;
    logic aw_hs, w_hs, ar_hs, r_hs;
    logic commit, start_wr, wr_is_tap, rd_is_tap;
    logic rd_stage1, rd_stage2, ctrl_read;
    logic ap_start, ap_done, ap_idle;

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;

    // write channel, wr_live holds both readies low for the first cycle
    assign awready = wr_live && ap_idle &&
                     (wr_state == fir_pkg::WR_WAIT_BOTH || wr_state == fir_pkg::WR_WAIT_ADDR);
    assign wready  = wr_live && ap_idle &&
                     (wr_state == fir_pkg::WR_WAIT_BOTH || wr_state == fir_pkg::WR_WAIT_DATA);

    always_comb begin
        wr_state_nx = wr_state;
        case (wr_state)
            fir_pkg::WR_WAIT_BOTH: begin
                if (aw_hs && w_hs)
                    wr_state_nx = fir_pkg::WR_COMMIT;
                else if (aw_hs)
                    wr_state_nx = fir_pkg::WR_WAIT_DATA;
                else if (w_hs)
                    wr_state_nx = fir_pkg::WR_WAIT_ADDR;
            end
            fir_pkg::WR_WAIT_ADDR: if (aw_hs) wr_state_nx = fir_pkg::WR_COMMIT;
            fir_pkg::WR_WAIT_DATA: if (w_hs) wr_state_nx = fir_pkg::WR_COMMIT;
            fir_pkg::WR_COMMIT:    if (commit) wr_state_nx = fir_pkg::WR_WAIT_BOTH;
            default:               wr_state_nx = fir_pkg::WR_WAIT_BOTH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= fir_pkg::WR_WAIT_BOTH;
            wr_live  <= 1'b0;
        end else begin
            wr_state <= wr_state_nx;
            wr_live  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) aw_q <= awaddr;
        if (w_hs)  w_q  <= wdata;
        if (ar_hs) ar_q <= araddr;
    end

    // a pending tap read owns the tap index, so the write waits one cycle
    assign commit   = (wr_state == fir_pkg::WR_COMMIT) && !rd_stage1;
    assign start_wr = commit && (aw_q == `FIR_REG_CTRL) && w_q[0];

    assign wr_off    = aw_q - `FIR_REG_TAP;
    assign rd_off    = ar_q - `FIR_REG_TAP;
    assign wr_is_tap = (aw_q >= `FIR_REG_TAP) && (wr_off < TAP_SPAN);
    assign rd_is_tap = (ar_q >= `FIR_REG_TAP) && (rd_off < TAP_SPAN);

    assign cfg_tap_we    = commit && wr_is_tap;
    assign cfg_tap_wdata = w_q;
    assign cfg_tap_idx   = cfg_tap_we ? fir_pkg::tap_idx_t'(wr_off >> 2) :
                           rd_is_tap  ? fir_pkg::tap_idx_t'(rd_off >> 2) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_length <= '0;
        end else if (commit && aw_q == `FIR_REG_LEN) begin
            data_length <= w_q;
        end
    end

    // control and status
    assign ctrl_read = rd_stage2 && (ar_q == `FIR_REG_CTRL);
    assign start     = ap_start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
        end else begin
            ap_start <= start_wr;      // single cycle
            if (run_end)
                ap_done <= 1'b1;
            else if (ctrl_read && ap_done)
                ap_done <= 1'b0;
            if (start_wr)
                ap_idle <= 1'b0;
            else if (ctrl_read && ap_done)
                ap_idle <= 1'b1;
        end
    end

    assign status = {{(`FIR_DATA_W-6){1'b0}}, out_valid, ss_ready, 1'b0,
                     ap_idle, ap_done, ap_start};

    // read path: address, ram access, then rdata
    assign arready = !(rd_stage1 || rd_stage2 || rvalid) && (wr_state != fir_pkg::WR_COMMIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_stage1 <= 1'b0;
            rd_stage2 <= 1'b0;
            rvalid    <= 1'b0;
        end else begin
            rd_stage1 <= ar_hs;
            rd_stage2 <= rd_stage1;
            if (rd_stage2)
                rvalid <= 1'b1;
            else if (r_hs)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stage2) begin
            if (ar_q == `FIR_REG_CTRL)
                rdata <= status;
            else if (ar_q == `FIR_REG_LEN)
                rdata <= data_length;
            else if (rd_is_tap && ap_idle)
                rdata <= tap_rdata;    // engine owns the tap ram during a run
            else
                rdata <= '0;
        end
    end

    rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- hw/fir_defs.svh
`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// datapath and register port widths
`define FIR_DATA_W 32
`define FIR_ADDR_W 12

// filter length
`define FIR_NUM_TAPS 11

// register byte offsets
`define FIR_REG_CTRL 12'h000
`define FIR_REG_LEN  12'h010
`define FIR_REG_TAP  12'h040

// 11 tap reads plus ram and multiplier latency
`define FIR_CALC_CYCLES 13

`endif

//--- hw/fir_engine.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               ss_tvalid,
    input  fir_pkg::fir_data_t ss_tdata,
    input  logic               ss_tlast,
    input  logic               sm_tready,
    input  logic               out_busy,
    input  logic               last_out,
    input  logic               cfg_tap_we,
    input  fir_pkg::tap_idx_t  cfg_tap_idx,
    input  fir_pkg::fir_data_t cfg_tap_wdata,
    output logic               ss_tready,
    output logic               run_end,
    output logic               sample_valid,
    output logic               tap_phase,
    output fir_pkg::tap_idx_t  tap_addr,
    output logic               tap_we,
    output fir_pkg::fir_data_t tap_wdata,
    output fir_pkg::tap_idx_t  data_addr,
    output logic               data_we,
    output fir_pkg::fir_data_t data_wdata
);

    localparam fir_pkg::tap_idx_t LAST_IDX  = `FIR_NUM_TAPS - 1;
    localparam fir_pkg::tap_idx_t CALC_LAST = `FIR_CALC_CYCLES - 1;

    fir_pkg::engine_state_t state, state_nx;
    fir_pkg::tap_idx_t cnt, wr_ptr, rd_ptr;
    logic last_seen, in_hs, calc_end;

    assign ss_tready    = (state == fir_pkg::ST_LOAD);
    assign in_hs        = ss_tready && ss_tvalid;
    assign sample_valid = in_hs;
    assign calc_end     = (state == fir_pkg::ST_CALC) && (cnt == CALC_LAST);
    assign run_end      = out_busy && sm_tready && last_out;

    always_comb begin
        state_nx = state;
        case (state)
            fir_pkg::ST_IDLE:  if (start) state_nx = fir_pkg::ST_CLEAR;
            fir_pkg::ST_CLEAR: if (cnt == LAST_IDX) state_nx = fir_pkg::ST_LOAD;
            fir_pkg::ST_LOAD:  if (in_hs) state_nx = fir_pkg::ST_CALC;
            fir_pkg::ST_CALC: begin
                if (calc_end)
                    state_nx = (last_seen || (out_busy && !sm_tready)) ?
                               fir_pkg::ST_HOLD : fir_pkg::ST_LOAD;
            end
            fir_pkg::ST_HOLD: begin
                if (last_seen && run_end)
                    state_nx = fir_pkg::ST_IDLE;     // final output taken
                else if (!last_seen && sm_tready)
                    state_nx = fir_pkg::ST_LOAD;
            end
            default: state_nx = fir_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fir_pkg::ST_IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nx;
            if (state_nx != state)
                cnt <= '0;
            else if (state == fir_pkg::ST_CLEAR || state == fir_pkg::ST_CALC)
                cnt <= cnt + 1'b1;
        end
    end

    // circular history, write moves up, read walks down from newest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            last_seen <= 1'b0;
        end else if (start) begin
            wr_ptr    <= '0;
            last_seen <= 1'b0;
        end else if (in_hs) begin
            wr_ptr    <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            rd_ptr    <= wr_ptr;
            last_seen <= ss_tlast;
        end else if (state == fir_pkg::ST_CALC) begin
            rd_ptr <= (rd_ptr == '0) ? LAST_IDX : rd_ptr - 1'b1;
        end
    end

    // tap ram, config side only while idle
    assign tap_phase = (state == fir_pkg::ST_CALC) && (cnt < `FIR_NUM_TAPS);
    assign tap_we    = (state == fir_pkg::ST_IDLE) && cfg_tap_we;
    assign tap_wdata = cfg_tap_wdata;

    always_comb begin
        if (state == fir_pkg::ST_IDLE)
            tap_addr = cfg_tap_idx;
        else if (tap_phase)
            tap_addr = cnt;              // h[k] in step with x[n-k]
        else
            tap_addr = '0;
    end

    // data ram
    assign data_we    = (state == fir_pkg::ST_CLEAR) || in_hs;
    assign data_wdata = (state == fir_pkg::ST_LOAD) ? ss_tdata : '0;

    always_comb begin
        case (state)
            fir_pkg::ST_CLEAR: data_addr = cnt;
            fir_pkg::ST_LOAD:  data_addr = wr_ptr;
            fir_pkg::ST_CALC:  data_addr = rd_ptr;
            default:           data_addr = '0;
        endcase
    end

    cfg_we_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_tap_we |-> state == fir_pkg::ST_IDLE);

endmodule

//--- hw/fir_mac.sv
`timescale 1ns/1ps

module fir_mac (
    input  logic               clk,
    input  logic               rst_n,
    input  fir_pkg::fir_data_t tap_q,
    input  fir_pkg::fir_data_t data_q,
    input  logic               sample_valid,
    input  logic               tap_phase,
    input  logic               ss_tlast_taken,
    input  logic               sm_tready,
    output logic               sm_tvalid,
    output fir_pkg::fir_data_t sm_tdata,
    output logic               sm_tlast,
    output logic               out_busy,
    output logic               last_out
);

    fir_pkg::fir_data_t prod, acc, acc_sum;
    logic rd_v, prod_v;
    logic sum_last, sum_pend, last_pend;
    logic out_v, out_take, load_now;

    // ram data lands one cycle after the tap phase, product one more
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_v   <= 1'b0;
            prod_v <= 1'b0;
        end else begin
            rd_v   <= tap_phase;
            prod_v <= rd_v;
        end
    end

    always_ff @(posedge clk) begin
        prod <= tap_q * data_q;          // wraps to 32 bits
    end

    assign acc_sum  = acc + prod;
    assign sum_last = prod_v && !rd_v;   // 11th product
    assign out_take = out_v && sm_tready;
    assign load_now = (sum_last || sum_pend) && (!out_v || sm_tready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc      <= '0;
            sum_pend <= 1'b0;
        end else begin
            if (load_now)
                acc <= '0;
            else if (prod_v)
                acc <= acc_sum;
            // output register still full, keep the sum in acc
            if (load_now)
                sum_pend <= 1'b0;
            else if (sum_last)
                sum_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_now)
            sm_tdata <= sum_last ? acc_sum : acc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_v     <= 1'b0;
            last_out  <= 1'b0;
            last_pend <= 1'b0;
        end else begin
            if (load_now)
                out_v <= 1'b1;
            else if (out_take)
                out_v <= 1'b0;
            if (sample_valid && ss_tlast_taken)
                last_pend <= 1'b1;       // final input now in flight
            else if (load_now)
                last_pend <= 1'b0;
            if (load_now)
                last_out <= last_pend;
            else if (out_take)
                last_out <= 1'b0;
        end
    end

    assign sm_tvalid = out_v;
    assign out_busy  = out_v;
    assign sm_tlast  = out_v && last_out;

    out_stall: assert property (@(posedge clk) disable iff (!rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata));

endmodule

//--- hw/fir_pkg.sv
`include "fir_defs.svh"

package fir_pkg;

    typedef logic [`FIR_DATA_W-1:0] fir_data_t;   // sample, coefficient or result
    typedef logic [`FIR_ADDR_W-1:0] fir_addr_t;   // register byte address
    typedef logic [3:0]             tap_idx_t;    // word index into either ram

    // run sequencer
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_LOAD,
        ST_CALC,
        ST_HOLD
    } engine_state_t;

    // register write channel
    typedef enum logic [1:0] {
        WR_WAIT_BOTH,
        WR_WAIT_ADDR,
        WR_WAIT_DATA,
        WR_COMMIT
    } wr_state_t;

endpackage

//--- hw/fir_top.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module fir_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               awvalid,
    output logic               awready,
    input  fir_pkg::fir_addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  fir_pkg::fir_data_t wdata,
    input  logic               arvalid,
    output logic               arready,
    input  fir_pkg::fir_addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output fir_pkg::fir_data_t rdata,
    input  logic               ss_tvalid,
    output logic               ss_tready,
    input  fir_pkg::fir_data_t ss_tdata,
    input  logic               ss_tlast,
    output logic               sm_tvalid,
    input  logic               sm_tready,
    output fir_pkg::fir_data_t sm_tdata,
    output logic               sm_tlast
);

    logic start, run_end, cfg_tap_we;
    fir_pkg::tap_idx_t  cfg_tap_idx, tap_addr, data_addr;
    fir_pkg::fir_data_t cfg_tap_wdata, tap_wdata, data_wdata, tap_q, data_q;
    logic tap_we, data_we, sample_valid, tap_phase, out_busy, last_out;

    axil_regs regs0 (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata,
        .run_end,
        .ss_ready  (ss_tready),
        .out_valid (sm_tvalid),
        .tap_rdata (tap_q),
        .start, .cfg_tap_we, .cfg_tap_idx, .cfg_tap_wdata
    );

    fir_engine engine0 (
        .clk, .rst_n, .start,
        .ss_tvalid, .ss_tdata, .ss_tlast, .sm_tready,
        .out_busy, .last_out,
        .cfg_tap_we, .cfg_tap_idx, .cfg_tap_wdata,
        .ss_tready, .run_end, .sample_valid, .tap_phase,
        .tap_addr, .tap_we, .tap_wdata,
        .data_addr, .data_we, .data_wdata
    );

    fir_mac mac0 (
        .clk, .rst_n, .tap_q, .data_q, .sample_valid, .tap_phase,
        .ss_tlast_taken (ss_tlast),   // qualified by sample_valid inside
        .sm_tready, .sm_tvalid, .sm_tdata, .sm_tlast,
        .out_busy, .last_out
    );

    // coefficients
    sync_ram #(.DEPTH(`FIR_NUM_TAPS)) tap_ram0 (
        .clk, .we(tap_we), .addr(tap_addr), .wdata(tap_wdata), .rdata(tap_q)
    );

    // sample history
    sync_ram #(.DEPTH(`FIR_NUM_TAPS)) data_ram0 (
        .clk, .we(data_we), .addr(data_addr), .wdata(data_wdata), .rdata(data_q)
    );

endmodule

//--- hw/sync_ram.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module sync_ram #(
    parameter int DEPTH = 11
) (
    input  logic                         clk,
    input  logic                         we,
    input  logic [$clog2(DEPTH)-1:0]     addr,
    input  logic [`FIR_DATA_W-1:0]       wdata,
    output logic [`FIR_DATA_W-1:0]       rdata
);

    logic [`FIR_DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the FIR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f fir.f --top-module tb_fir -Mdir obj_dir -o tb_fir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/tb_fir
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0

//--- verif/tb_fir_ref.svh
`ifndef TB_FIR_REF_SVH
`define TB_FIR_REF_SVH

`include "fir_defs.svh"

// 32-bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// byte address of coefficient idx
function automatic fir_pkg::fir_addr_t tap_reg_addr(input int idx);
    return fir_pkg::fir_addr_t'(`FIR_REG_TAP + 4 * idx);
endfunction

// y[n] = sum of h[k] * x[n-k], win[k] holds x[n-k]
// entries before the first sample of a run stay zero
function automatic fir_pkg::fir_data_t fir_ref(
    input fir_pkg::fir_data_t h   [`FIR_NUM_TAPS],
    input fir_pkg::fir_data_t win [`FIR_NUM_TAPS]
);
    fir_pkg::fir_data_t acc;
    fir_pkg::fir_data_t prod;
    acc = '0;
    for (int k = 0; k < `FIR_NUM_TAPS; k++) begin
        prod = h[k] * win[k];    // low 32 bits only
        acc  = acc + prod;
    end
    return acc;
endfunction

`endif

//--- verif/tb_fir.sv
`timescale 1ns/1ps
`include "fir_defs.svh"

module tb_fir;

    localparam int RUN_LEN     = 20;
    localparam int NUM_RUNS    = 2;
    localparam int WDOG_CYCLES = 40 * RUN_LEN * NUM_RUNS + 2000;
    localparam logic [31:0] SEED = 32'd86820;

    logic clk, rst_n;
    logic awvalid, awready, wvalid, wready, arvalid, arready, rvalid, rready;
    fir_pkg::fir_addr_t awaddr, araddr;
    fir_pkg::fir_data_t wdata, rdata, ss_tdata, sm_tdata;
    logic ss_tvalid, ss_tready, ss_tlast, sm_tvalid, sm_tready, sm_tlast;

    fir_pkg::fir_data_t taps [`FIR_NUM_TAPS];
    fir_pkg::fir_data_t win  [`FIR_NUM_TAPS];   // newest sample at index 0
    fir_pkg::fir_data_t exp_data [$];
    logic exp_last [$];
    logic [31:0] rng, stall_rng;
    logic stall_mode, late_wr_done;
    int out_count;
    string test_name;

    `include "tb_fir_ref.svh"

    fir_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic axil_write(input fir_pkg::fir_addr_t addr, input fir_pkg::fir_data_t data);
        logic aw_done, w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            if (awvalid && awready) aw_done = 1'b1;
            if (wvalid && wready) w_done = 1'b1;
            @(posedge clk);
            #1;
            if (aw_done) awvalid = 1'b0;
            if (w_done) wvalid = 1'b0;
        end
    endtask

    task automatic axil_read(input fir_pkg::fir_addr_t addr, output fir_pkg::fir_data_t data);
        logic hs;
        araddr  = addr;
        arvalid = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs = arready;
            @(posedge clk);
            #1;
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        hs = 1'b0;
        while (!hs) begin
            @(negedge clk);
            hs   = rvalid;
            data = rdata;
            @(posedge clk);
            #1;
        end
        rready = 1'b0;
    endtask

    task automatic drive_samples(input int n);
        logic hs;
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            for (int k = `FIR_NUM_TAPS - 1; k > 0; k--) begin
                win[k] = win[k-1];
            end
            win[0]    = rng;
            ss_tdata  = rng;
            ss_tlast  = (i == n - 1);
            ss_tvalid = 1'b1;
            hs = 1'b0;
            while (!hs) begin
                @(negedge clk);
                hs = ss_tready;
                if (hs) begin
                    exp_data.push_back(fir_ref(taps, win));
                    exp_last.push_back(ss_tlast);
                end
                @(posedge clk);
                #1;
            end
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic start_run(input string name, input logic stall);
        test_name  = name;
        stall_mode = stall;
        out_count  = 0;
        foreach (win[k]) begin
            win[k] = '0;    // dut clears its history too
        end
        axil_write(`FIR_REG_CTRL, 32'h1);
    endtask

    task automatic wait_outputs(input int n);
        while (out_count < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // output sink with rare ready in stall mode so outputs back up into hold
    initial begin
        forever begin
            @(posedge clk);
            #1;
            stall_rng = xorshift32(stall_rng);
            sm_tready = stall_mode ? (stall_rng[3:0] == 4'h0) : 1'b1;
        end
    end

    // compare every output handshake against the reference queue
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && sm_tvalid && sm_tready) begin
                if (exp_data.size() == 0) begin
                    $display("output with no input waiting for it in %s", test_name);
                    stop_on_error();
                end else begin
                    check({test_name, " tdata"}, exp_data.pop_front(), sm_tdata);
                    check({test_name, " tlast"}, 32'(exp_last.pop_front()), 32'(sm_tlast));
                    out_count++;
                end
            end
        end
    end

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WDOG_CYCLES);
        stop_on_error();
    end

    initial begin
        fir_pkg::fir_data_t rd;
        rst_n     = 1'b0;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        ss_tlast  = 1'b0;
        sm_tready = 1'b1;
        rng        = SEED;
        stall_rng  = SEED ^ 32'h0000_ffff;
        stall_mode = 1'b0;
        late_wr_done = 1'b0;
        out_count  = 0;
        test_name  = "reset status";
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        axil_read(`FIR_REG_CTRL, rd);
        check(test_name, 32'h4, rd);    // idle only

        for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
            rng = xorshift32(rng);
            taps[i] = rng;
            axil_write(tap_reg_addr(i), rng);
        end
        for (int i = 0; i < `FIR_NUM_TAPS; i++) begin
            axil_read(tap_reg_addr(i), rd);
            check("tap readback", taps[i], rd);
        end

        axil_write(`FIR_REG_LEN, RUN_LEN);
        axil_read(`FIR_REG_LEN, rd);
        check("length readback", RUN_LEN, rd);

        start_run("run without stalls", 1'b0);
        drive_samples(RUN_LEN);
        wait_outputs(RUN_LEN);

        axil_read(`FIR_REG_CTRL, rd);
        check("done status", 32'h2, rd);
        axil_read(`FIR_REG_CTRL, rd);
        check("idle after done read", 32'h4, rd);

        start_run("run with stalls", 1'b1);
        fork
            begin
                axil_write(`FIR_REG_LEN, 32'd33);   // held off until idle
                late_wr_done = 1'b1;
            end
        join_none
        fork
            drive_samples(RUN_LEN);
            begin
                axil_read(tap_reg_addr(3), rd);
                check("tap read during run", 0, rd);
            end
        join
        wait_outputs(RUN_LEN);
        check("write held while busy", 0, 32'(late_wr_done));

        axil_read(`FIR_REG_CTRL, rd);
        check("done status after stalls", 32'h2, rd);
        while (!late_wr_done) begin
            @(posedge clk);
            #1;
        end
        axil_read(`FIR_REG_LEN, rd);
        check("length after late write", 32'd33, rd);
        stall_mode = 1'b0;

        $display("Finished with no errors");
        $finish;
    end

endmodule
